//--- include/mem_stage_defines.svh
// memory stage widths and privilege mode
// address windows, timer register map, region codes
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// ----------------------------------------
// widths fixed by the ISA
`define XLEN_W          32
`define ADDR_W          32
`define SIZE_W          3              // bytes: 1, 2 or 4
`define RADDR_W         5
`define MODE_W          2
`define REGION_W        3
`define MODE_MACHINE    2'd3           // only mode allowed on timer regs

// ----------------------------------------
// address windows, mutually exclusive
`define PHY_LO          32'h1000_0000  // data cache
`define PHY_HI          32'h1FFF_FFFF
`define EXT_IO_LO       32'h4000_0000  // external I/O bus
`define EXT_IO_HI       32'h4FFF_FFFF
`define INT_IO_LO       32'hFFFF_0000  // machine timer block
`define INT_IO_HI       32'hFFFF_00FF

// timer registers, hi halves at base + 4
`define MTIME_ADDR      32'hFFFF_0000
`define MTIMECMP_ADDR   32'hFFFF_0008
`define MSIP_ADDR       32'hFFFF_0010

// region codes
`define REGION_NONE     3'd0           // no access this cycle
`define REGION_PHY      3'd1
`define REGION_INT      3'd2
`define REGION_EXT      3'd3
`define REGION_UNMAPPED 3'd4
`endif

//--- mem_stage.f
+incdir+include
rtl/mem_stage_pkg.sv
rtl/mio_if.sv
rtl/mem_stage_ctrl.sv
rtl/mem_int_io.sv
rtl/mem_bus_router.sv
rtl/mem_wb_reg.sv
rtl/mem_stage.sv
testbench/tb_mem_stage.sv

//--- rtl/mem_bus_router.sv
// routes one access to the data cache or external I/O bus
// and merges the acknowledges of all regions
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_bus_router
(
   input  logic                 dc_ack,
   input  mem_stage_pkg::xlen_t dc_ack_data,
   input  logic                 dc_ack_fault,
   input  logic                 eio_ack,
   input  mem_stage_pkg::xlen_t eio_ack_data,
   input  logic                 eio_ack_fault,
   output logic                 dc_req,
   output logic                 dc_rd,
   output logic                 dc_wr,
   output mem_stage_pkg::addr_t dc_addr,
   output mem_stage_pkg::xlen_t dc_wr_data,
   output logic                 eio_req,
   output logic                 eio_rd,
   output logic                 eio_wr,
   output mem_stage_pkg::addr_t eio_addr,
   output mem_stage_pkg::xlen_t eio_wr_data,
   mio_if.router                mio
);

   logic sel_ext;

   // ---------------------------------------
   // data cache, fields pass through, req qualifies them
   assign dc_req     = mio.req & (mio.region == `REGION_PHY);
   assign dc_rd      = mio.is_ld;
   assign dc_wr      = mio.is_st;
   assign dc_addr    = mio.addr;
   assign dc_wr_data = mio.st_data;

   // external bus sees zeros unless selected
   assign sel_ext = mio.req & (mio.region == `REGION_EXT);

   always_comb
   begin
      eio_req     = 1'b0;
      eio_rd      = 1'b0;
      eio_wr      = 1'b0;
      eio_addr    = '0;
      eio_wr_data = '0;
      if (sel_ext)
      begin
         eio_req     = 1'b1;
         eio_rd      = mio.is_ld;
         eio_wr      = mio.is_st;
         eio_addr    = mio.addr;
         eio_wr_data = mio.st_data;
      end
   end

   // ---------------------------------------
   // acknowledge merge
   always_comb
   begin
      mio.ack       = 1'b0;
      mio.ack_data  = '0;
      mio.ack_fault = 1'b0;
      case (mio.region)
         `REGION_PHY:
         begin
            mio.ack       = dc_ack;            // cache decides the latency
            mio.ack_data  = dc_ack_data;
            mio.ack_fault = dc_ack_fault;
         end
         `REGION_INT:
         begin
            mio.ack       = mio.int_ack;       // same cycle
            mio.ack_data  = mio.int_data;
            mio.ack_fault = mio.int_fault;
         end
         `REGION_EXT:
         begin
            mio.ack       = eio_ack;
            mio.ack_fault = eio_ack_fault;
            if (mio.is_ld & !eio_ack_fault)
               mio.ack_data = eio_ack_data;    // faulted load returns zero
         end
         `REGION_UNMAPPED:
         begin
            mio.ack       = mio.req;           // abort at once
            mio.ack_fault = mio.req;
         end
         default:
         begin
            mio.ack       = 1'b0;              // idle, nothing to answer
         end
      endcase
   end

endmodule

//--- rtl/mem_int_io.sv
// internal I/O: machine timer and msip register access,
// write strobes, read mux and access faults
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_int_io
(
   input  logic                  xfer_in,
   input  mem_stage_pkg::dword_t mtime,
   input  mem_stage_pkg::dword_t mtimecmp,
   input  mem_stage_pkg::xlen_t  msip_reg,
   output logic                  mtime_lo_wr,
   output logic                  mtime_hi_wr,
   output logic                  mtimecmp_lo_wr,
   output logic                  mtimecmp_hi_wr,
   output logic                  msip_wr,
   output mem_stage_pkg::xlen_t  mmr_wr_data,
   mio_if.int_io                 mio
);
   import mem_stage_pkg::*;

   logic  sel;                                 // access decoded to this block
   logic  mach;
   logic  hit_mtime_lo;
   logic  hit_mtime_hi;
   logic  hit_cmp_lo;
   logic  hit_cmp_hi;
   logic  hit_msip;
   logic  known;
   logic  wr_ok;
   xlen_t rd_word;

   assign sel  = (mio.region == `REGION_INT);
   assign mach = (mio.mode == `MODE_MACHINE);

   assign hit_mtime_lo = (mio.addr == `MTIME_ADDR);
   assign hit_mtime_hi = (mio.addr == (`MTIME_ADDR + 32'd4));
   assign hit_cmp_lo   = (mio.addr == `MTIMECMP_ADDR);
   assign hit_cmp_hi   = (mio.addr == (`MTIMECMP_ADDR + 32'd4));
   assign hit_msip     = (mio.addr == `MSIP_ADDR);
   assign known = hit_mtime_lo | hit_mtime_hi | hit_cmp_lo | hit_cmp_hi | hit_msip;
   assign wr_ok = sel & mach & known & mio.is_st;   // machine mode store to a real register

   // ---------------------------------------
   // read side
   always_comb
   begin
      rd_word = '0;
      if (hit_mtime_lo)
         rd_word = mtime[`XLEN_W-1:0];
      else if (hit_mtime_hi)
         rd_word = mtime[2*`XLEN_W-1:`XLEN_W];
      else if (hit_cmp_lo)
         rd_word = mtimecmp[`XLEN_W-1:0];
      else if (hit_cmp_hi)
         rd_word = mtimecmp[2*`XLEN_W-1:`XLEN_W];
      else if (hit_msip)
         rd_word = msip_reg;
   end

   // ---------------------------------------
   // answer, every internal access is acknowledged at once
   assign mio.int_ack   = sel;
   assign mio.int_data  = (sel & mach & mio.is_ld) ? rd_word : '0;
   assign mio.int_fault = sel & !(mach & known);   // wrong mode or no such register

   // write strobes, only in the transfer cycle
   assign mtime_lo_wr    = wr_ok & xfer_in & hit_mtime_lo;
   assign mtime_hi_wr    = wr_ok & xfer_in & hit_mtime_hi;
   assign mtimecmp_lo_wr = wr_ok & xfer_in & hit_cmp_lo;
   assign mtimecmp_hi_wr = wr_ok & xfer_in & hit_cmp_hi;
   assign msip_wr        = wr_ok & xfer_in & hit_msip;
   assign mmr_wr_data    = mio.st_data;

   // ---------------------------------------
   // checks
   a_one_strobe: assert property (@(posedge mio.clk_in)
      $onehot0({mtime_lo_wr, mtime_hi_wr, mtimecmp_lo_wr, mtimecmp_hi_wr, msip_wr}));

endmodule

//--- rtl/mem_stage.sv
// memory stage top level
// control, internal I/O, bus router and write-back register
`timescale 1ns/1ps

module mem_stage
(
   input  logic                  clk_in,
   input  logic                  arst_n,
   input  logic                  cpu_halt,
   input  logic                  pipe_flush,
   // execute side
   input  logic                  e2m_valid,
   output logic                  e2m_rdy,
   input  logic                  e2m_is_ld,
   input  logic                  e2m_is_st,
   input  mem_stage_pkg::addr_t  e2m_addr,
   input  mem_stage_pkg::xlen_t  e2m_st_data,
   input  mem_stage_pkg::size_t  e2m_size,
   input  logic                  e2m_zero_ext,
   input  mem_stage_pkg::mode_t  e2m_mode,
   input  logic                  e2m_rd_wr,
   input  mem_stage_pkg::raddr_t e2m_rd_addr,
   input  mem_stage_pkg::xlen_t  e2m_rd_data,
   // data cache
   output logic                  dc_req,
   output logic                  dc_rd,
   output logic                  dc_wr,
   output mem_stage_pkg::addr_t  dc_addr,
   output mem_stage_pkg::xlen_t  dc_wr_data,
   output mem_stage_pkg::size_t  dc_size,
   output logic                  dc_zero_ext,
   input  logic                  dc_ack,
   input  mem_stage_pkg::xlen_t  dc_ack_data,
   input  logic                  dc_ack_fault,
   // external I/O
   output logic                  eio_req,
   output logic                  eio_rd,
   output logic                  eio_wr,
   output mem_stage_pkg::addr_t  eio_addr,
   output mem_stage_pkg::xlen_t  eio_wr_data,
   input  logic                  eio_ack,
   input  mem_stage_pkg::xlen_t  eio_ack_data,
   input  logic                  eio_ack_fault,
   // machine timer registers
   input  mem_stage_pkg::dword_t mtime,
   input  mem_stage_pkg::dword_t mtimecmp,
   input  mem_stage_pkg::xlen_t  msip_reg,
   output logic                  mtime_lo_wr,
   output logic                  mtime_hi_wr,
   output logic                  mtimecmp_lo_wr,
   output logic                  mtimecmp_hi_wr,
   output logic                  msip_wr,
   output mem_stage_pkg::xlen_t  mmr_wr_data,
   // write-back side
   output logic                  m2w_valid,
   input  logic                  m2w_rdy,
   output logic                  m2w_rd_wr,
   output mem_stage_pkg::raddr_t m2w_rd_addr,
   output mem_stage_pkg::xlen_t  m2w_rd_data,
   output mem_stage_pkg::addr_t  m2w_ls_addr,
   output logic                  m2w_fault
);

   logic xfer_in;                              // execute -> memory transfer

   mio_if mio (.clk_in(clk_in));

   // size and zero-extend only matter to the cache
   assign dc_size     = e2m_size;
   assign dc_zero_ext = e2m_zero_ext;

   mem_stage_ctrl ctrl_inst     (.mio(mio), .*);
   mem_int_io     int_io_inst   (.mio(mio), .*);
   mem_bus_router router_inst   (.mio(mio), .*);
   mem_wb_reg     wb_reg_inst   (.mio(mio), .*);

endmodule

//--- rtl/mem_stage_ctrl.sv
// memory stage control: output register full flag, handshakes,
// request gating and address region decode
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_stage_ctrl
(
   input  logic                 clk_in,
   input  logic                 arst_n,
   input  logic                 cpu_halt,
   input  logic                 pipe_flush,
   input  logic                 e2m_valid,
   input  logic                 e2m_is_ld,
   input  logic                 e2m_is_st,
   input  mem_stage_pkg::addr_t e2m_addr,
   input  mem_stage_pkg::xlen_t e2m_st_data,
   input  mem_stage_pkg::mode_t e2m_mode,
   input  logic                 m2w_rdy,
   output logic                 e2m_rdy,
   output logic                 m2w_valid,
   output logic                 xfer_in,       // execute -> memory transfer
   mio_if.ctrl                  mio
);

   logic full;                                 // output register holds an item
   logic xfer_out;                             // memory -> write-back transfer
   logic is_ls;
   logic room;                                 // register empty or draining now
   logic in_phy;
   logic in_int;
   logic in_ext;

   // ---------------------------------------
   // handshakes
   assign is_ls     = e2m_is_ld | e2m_is_st;
   assign m2w_valid = full & !cpu_halt;        // halt freezes the output side too
   assign xfer_out  = m2w_valid & m2w_rdy;
   assign room      = !full | xfer_out;

   // rdy only toward a presented instruction; load/store waits for ack
   assign e2m_rdy = e2m_valid & !cpu_halt & (!is_ls | mio.ack) & room;
   assign xfer_in = e2m_valid & e2m_rdy;

   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         full <= 1'b0;
      else if (pipe_flush)
         full <= 1'b0;                         // drop the item in flight
      else if (xfer_in)
         full <= 1'b1;
      else if (xfer_out)
         full <= 1'b0;
   end

   // ---------------------------------------
   // request, held back while the register cannot take the result
   assign mio.req     = e2m_valid & !cpu_halt & is_ls & room;
   assign mio.is_ld   = e2m_is_ld;
   assign mio.is_st   = e2m_is_st;
   assign mio.addr    = e2m_addr;
   assign mio.st_data = e2m_st_data;
   assign mio.mode    = e2m_mode;

   assign in_phy = (e2m_addr >= `PHY_LO)    & (e2m_addr <= `PHY_HI);
   assign in_int = (e2m_addr >= `INT_IO_LO) & (e2m_addr <= `INT_IO_HI);
   assign in_ext = (e2m_addr >= `EXT_IO_LO) & (e2m_addr <= `EXT_IO_HI);

   always_comb
   begin
      if (!mio.req)
         mio.region = `REGION_NONE;
      else if (in_phy)
         mio.region = `REGION_PHY;
      else if (in_int)
         mio.region = `REGION_INT;
      else if (in_ext)
         mio.region = `REGION_EXT;
      else
         mio.region = `REGION_UNMAPPED;        // answered at once with a fault
   end

   // ---------------------------------------
   // checks
   // windows are disjoint, so the priority order above never hides one
   a_region_window: assert property (@(posedge clk_in) disable iff (!arst_n)
      $onehot0({in_phy, in_int, in_ext}));

   // a stalled result stays offered until write-back takes it
   a_m2w_hold: assert property (@(posedge clk_in) disable iff (!arst_n)
      ($past(m2w_valid & !m2w_rdy & !pipe_flush) & !cpu_halt) |-> m2w_valid);

endmodule

//--- rtl/mem_stage_pkg.sv
// vector types of the memory stage
`include "mem_stage_defines.svh"

package mem_stage_pkg;

   typedef logic [`XLEN_W-1:0]   xlen_t;    // one data word
   typedef logic [`ADDR_W-1:0]   addr_t;    // load/store address
   typedef logic [2*`XLEN_W-1:0] dword_t;   // mtime / mtimecmp value
   typedef logic [`SIZE_W-1:0]   size_t;    // access size in bytes
   typedef logic [`RADDR_W-1:0]  raddr_t;   // destination register index
   typedef logic [`MODE_W-1:0]   mode_t;    // privilege mode

   // which target an access goes to, see REGION_* codes
   typedef logic [`REGION_W-1:0] region_t;

endpackage

//--- rtl/mem_wb_reg.sv
// memory to write-back pipeline register
// load data or execute result, plus access fault
`timescale 1ns/1ps

module mem_wb_reg
(
   input  logic                  clk_in,
   input  logic                  arst_n,
   input  logic                  xfer_in,
   input  logic                  e2m_rd_wr,
   input  mem_stage_pkg::raddr_t e2m_rd_addr,
   input  mem_stage_pkg::xlen_t  e2m_rd_data,
   input  mem_stage_pkg::addr_t  e2m_addr,
   output logic                  m2w_rd_wr,
   output mem_stage_pkg::raddr_t m2w_rd_addr,
   output mem_stage_pkg::xlen_t  m2w_rd_data,
   output mem_stage_pkg::addr_t  m2w_ls_addr,
   output logic                  m2w_fault,
   mio_if.wb                     mio
);
   import mem_stage_pkg::*;

   xlen_t rd_next;
   logic  fault_next;

   // loads take the acknowledged word, everything else the alu result
   assign rd_next    = mio.is_ld ? mio.ack_data : e2m_rd_data;
   assign fault_next = (mio.is_ld | mio.is_st) & mio.ack_fault;

   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
      begin
         m2w_rd_wr   <= 1'b0;
         m2w_rd_addr <= '0;
         m2w_rd_data <= '0;
         m2w_ls_addr <= '0;
         m2w_fault   <= 1'b0;
      end
      else if (xfer_in)                        // one item in flight
      begin
         m2w_rd_wr   <= e2m_rd_wr;
         m2w_rd_addr <= e2m_rd_addr;
         m2w_rd_data <= rd_next;
         m2w_ls_addr <= e2m_addr;              // for fault reporting in write-back
         m2w_fault   <= fault_next;
      end
   end

endmodule

//--- rtl/mio_if.sv
// one memory access shared by control, internal I/O,
// bus router and write-back register
`timescale 1ns/1ps

interface mio_if (input logic clk_in);
   import mem_stage_pkg::*;

   // request, from control
   logic    req;          // level, held with its fields until ack
   region_t region;       // REGION_NONE when idle
   logic    is_ld;
   logic    is_st;
   addr_t   addr;
   xlen_t   st_data;
   mode_t   mode;

   // internal I/O answer, same cycle
   logic    int_ack;
   xlen_t   int_data;
   logic    int_fault;

   // merged answer of whichever region was hit
   logic    ack;
   xlen_t   ack_data;
   logic    ack_fault;

   modport ctrl   (output req, region, is_ld, is_st, addr, st_data, mode,
                   input  ack);
   modport int_io (input  clk_in, region, is_ld, is_st, addr, st_data, mode,
                   output int_ack, int_data, int_fault);
   modport router (input  req, region, is_ld, is_st, addr, st_data,
                   input  int_ack, int_data, int_fault,
                   output ack, ack_data, ack_fault);
   modport wb     (input  is_ld, is_st, ack_data, ack_fault);
endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mem_stage -f mem_stage.f -o sim_mem_stage

# a failing run still prints its output before the verdict
sim_out=$(./obj_dir/sim_mem_stage || true)
echo "$sim_out"

if grep -qx "TEST PASS" <<< "$sim_out"
then
   exit 0
fi
exit 1

//--- testbench/mem_stage_golden.txt
# op (0 none, 1 load, 2 store)  mode  addr  st_data  rd_addr  exp_rd_data  exp_fault
# all hex; st_data is also driven as the execute result on e2m_rd_data
0 3 00000000 0badf00d 01 0badf00d 0
2 0 10000040 cafe0001 02 cafe0001 0
1 0 10000040 11111111 03 cafe0001 0
2 3 1ffffffc 12345678 04 12345678 0
1 3 1ffffffc 22222222 05 12345678 0
1 3 ffff0000 33333333 06 89abcdef 0
1 3 ffff0004 44444444 07 01234567 0
1 3 ffff0008 55555555 08 76543210 0
1 3 ffff000c 66666666 09 fedcba98 0
1 3 ffff0010 77777777 0a 00000001 0
2 3 ffff0000 a0a0a0a0 0b a0a0a0a0 0
2 3 ffff000c b1b1b1b1 0c b1b1b1b1 0
2 3 ffff0010 00000001 0d 00000001 0
2 1 ffff0004 99999999 0e 99999999 1
2 3 ffff0020 abababab 0f abababab 1
1 3 00001000 cdcdcdcd 10 00000000 1
2 3 80000000 efefefef 11 efefefef 1
1 0 40000100 12121212 12 1a5a0100 0
1 0 40000108 13131313 13 00000000 1
2 0 40000200 14141414 14 14141414 0
0 0 00000000 5555aaaa 15 5555aaaa 0
1 0 10000080 16161616 16 efffff7f 0
0 3 00000000 deadbeef 1f deadbeef 0

//--- testbench/tb_mem_stage.sv
// memory stage testbench
// golden file driver, cache and external I/O models, result checks
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module tb_mem_stage;
   import mem_stage_pkg::*;

   localparam int         MAX_LINES = 64;
   localparam logic [3:0] OP_LD     = 4'd1;
   localparam logic [3:0] OP_ST     = 4'd2;
   localparam dword_t     MTIME_VAL = 64'h0123_4567_89ab_cdef;
   localparam dword_t     CMP_VAL   = 64'hfedc_ba98_7654_3210;

   logic   clk_in, arst_n, cpu_halt, pipe_flush;
   logic   e2m_valid, e2m_rdy, e2m_is_ld, e2m_is_st, e2m_zero_ext, e2m_rd_wr;
   addr_t  e2m_addr;
   xlen_t  e2m_st_data, e2m_rd_data;
   size_t  e2m_size;
   mode_t  e2m_mode;
   raddr_t e2m_rd_addr;
   logic   dc_req, dc_rd, dc_wr, dc_zero_ext;
   addr_t  dc_addr;
   xlen_t  dc_wr_data;
   size_t  dc_size;
   logic   dc_ack = 1'b0;                     // model outputs start idle
   xlen_t  dc_ack_data = '0;
   logic   dc_ack_fault = 1'b0;
   logic   eio_req, eio_rd, eio_wr;
   addr_t  eio_addr;
   xlen_t  eio_wr_data;
   logic   eio_ack = 1'b0;
   xlen_t  eio_ack_data = '0;
   logic   eio_ack_fault = 1'b0;
   dword_t mtime, mtimecmp;
   xlen_t  msip_reg;
   logic   mtime_lo_wr, mtime_hi_wr, mtimecmp_lo_wr, mtimecmp_hi_wr, msip_wr;
   xlen_t  mmr_wr_data;
   logic   m2w_valid, m2w_rd_wr, m2w_fault;
   logic   m2w_rdy = 1'b0;
   raddr_t m2w_rd_addr;
   xlen_t  m2w_rd_data;
   addr_t  m2w_ls_addr;

   // golden lines
   logic [3:0] op_q [MAX_LINES];
   mode_t      mode_q [MAX_LINES];
   addr_t      addr_q [MAX_LINES];
   xlen_t      data_q [MAX_LINES];              // store data and alu result
   raddr_t     rd_q [MAX_LINES];
   xlen_t      exp_q [MAX_LINES];
   logic       fault_q [MAX_LINES];
   int         strobe_cnt [MAX_LINES];
   int         n_lines = 0;
   int         cur = 0;                         // line presented to the DUT
   int         wb_idx = 0;                      // next line expected at write-back
   int         cycles = 0;
   int         cycle_limit = 1000;
   integer     seed = 32'h4c1d;
   xlen_t      cache_mem [addr_t];
   logic       dc_busy = 1'b0;
   logic [1:0] dc_left = '0;
   logic       eio_busy = 1'b0;
   logic [1:0] eio_left = '0;

   mem_stage mem_stage_inst (.*);

   // ----------------------------------------
   // failure reporting and compares
   task automatic abort_run(string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_word(string what, xlen_t got, xlen_t exp);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_addr(string what, addr_t got, addr_t exp);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_raddr(string what, raddr_t got, raddr_t exp);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_size(string what, size_t got, size_t exp);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_flag(string what, logic got, logic exp);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   task automatic check_strobe(string what, logic [4:0] got, logic [4:0] exp);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   // address windows as the memory map gives them
   function automatic region_t region_of(addr_t a);
      if (a >= `PHY_LO && a <= `PHY_HI)
         return `REGION_PHY;
      if (a >= `INT_IO_LO && a <= `INT_IO_HI)
         return `REGION_INT;
      if (a >= `EXT_IO_LO && a <= `EXT_IO_HI)
         return `REGION_EXT;
      return `REGION_UNMAPPED;
   endfunction

   // strobe order: mtime lo, mtime hi, mtimecmp lo, mtimecmp hi, msip
   function automatic logic [4:0] strobe_for(int i);
      if (op_q[i] != OP_ST || fault_q[i] || region_of(addr_q[i]) != `REGION_INT)
         return 5'b0;
      case (addr_q[i])
         `MTIME_ADDR:            return 5'b10000;
         `MTIME_ADDR + 32'd4:    return 5'b01000;
         `MTIMECMP_ADDR:         return 5'b00100;
         `MTIMECMP_ADDR + 32'd4: return 5'b00010;
         `MSIP_ADDR:             return 5'b00001;
         default:                return 5'b00000;
      endcase
   endfunction

   // ----------------------------------------
   // clock, timeout, back-pressure
   initial
   begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;          // 100 ns period
   end

   always @(posedge clk_in)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
         abort_run($sformatf("timeout after %0d cycles, %0d results seen", cycles, wb_idx));
   end

   always @(posedge clk_in)
   begin : wb_stall
      logic [31:0] rnd;
      rnd = $random(seed);
      m2w_rdy <= (rnd[1:0] != 2'd0);         // drop ready about a quarter of the time
   end

   // ----------------------------------------
   // data cache model, 1 to 4 cycles of extra latency
   always @(posedge clk_in or negedge arst_n)
   begin : cache_model
      logic [31:0] rnd;
      if (!arst_n)
      begin
         dc_ack  <= 1'b0;
         dc_busy <= 1'b0;
      end
      else
      begin
         dc_ack <= 1'b0;                      // one cycle pulse
         if (dc_req && !dc_ack)
         begin
            if (!dc_busy)
            begin
               rnd = $random(seed);
               dc_busy <= 1'b1;
               dc_left <= rnd[1:0];
            end
            else if (dc_left != 2'd0)
               dc_left <= dc_left - 2'd1;
            else
            begin
               dc_busy      <= 1'b0;
               dc_ack       <= 1'b1;
               dc_ack_fault <= 1'b0;
               if (dc_wr)
                  cache_mem[dc_addr] = dc_wr_data;
               // unwritten words read back as the inverted address
               dc_ack_data <= cache_mem.exists(dc_addr) ? cache_mem[dc_addr] : ~dc_addr;
            end
         end
      end
   end

   // external I/O model, data is addr ^ 5a5a_0000, bit 3 faults
   always @(posedge clk_in or negedge arst_n)
   begin : ext_io_model
      logic [31:0] rnd;
      if (!arst_n)
      begin
         eio_ack  <= 1'b0;
         eio_busy <= 1'b0;
      end
      else
      begin
         eio_ack <= 1'b0;
         if (eio_req && !eio_ack)
         begin
            if (!eio_busy)
            begin
               rnd = $random(seed);
               eio_busy <= 1'b1;
               eio_left <= rnd[1:0];
            end
            else if (eio_left != 2'd0)
               eio_left <= eio_left - 2'd1;
            else
            begin
               eio_busy      <= 1'b0;
               eio_ack       <= 1'b1;
               eio_ack_data  <= eio_addr ^ 32'h5a5a_0000;
               eio_ack_fault <= eio_addr[3];
            end
         end
      end
   end

   // ----------------------------------------
   // watchers, sampled away from the rising edge
   always @(negedge clk_in)
   begin : watch
      logic [4:0] strobes;
      strobes = {mtime_lo_wr, mtime_hi_wr, mtimecmp_lo_wr, mtimecmp_hi_wr, msip_wr};
      if (arst_n)
      begin
         if (dc_req && region_of(addr_q[cur]) != `REGION_PHY)
            abort_run($sformatf("cache request for non-cache address at line %0d", cur));
         if (dc_req)
         begin
            check_addr("dc_addr", dc_addr, addr_q[cur]);
            check_flag("dc_rd", dc_rd, op_q[cur] == OP_LD);
            check_flag("dc_wr", dc_wr, op_q[cur] == OP_ST);
            check_size("dc_size", dc_size, e2m_size);
            check_flag("dc_zero_ext", dc_zero_ext, e2m_zero_ext);
         end
         if (eio_req && region_of(addr_q[cur]) != `REGION_EXT)
            abort_run($sformatf("external request for non-external address at line %0d", cur));
         if (eio_req)
         begin
            check_addr("eio_addr", eio_addr, addr_q[cur]);
            check_flag("eio_rd", eio_rd, op_q[cur] == OP_LD);
            check_flag("eio_wr", eio_wr, op_q[cur] == OP_ST);
            if (op_q[cur] == OP_ST)
               check_word("eio_wr_data", eio_wr_data, data_q[cur]);
         end
         else
         begin
            check_addr("eio_addr while idle", eio_addr, '0);
            check_word("eio_wr_data while idle", eio_wr_data, '0);
            check_flag("eio_rd while idle", eio_rd, 1'b0);
            check_flag("eio_wr while idle", eio_wr, 1'b0);
         end
         if (strobes != 5'b0)
         begin
            if (!(e2m_valid && e2m_rdy))
               abort_run("timer strobe outside an execute transfer");
            if (strobe_cnt[cur] != 0)
               abort_run($sformatf("second timer strobe for line %0d", cur));
            strobe_cnt[cur] = 1;
            check_strobe("timer strobes", strobes, strobe_for(cur));
            check_word("mmr_wr_data", mmr_wr_data, data_q[cur]);
         end
         if (m2w_valid && m2w_rdy)
         begin
            if (wb_idx >= n_lines)
               abort_run("write-back result with no golden line left");
            check_raddr($sformatf("m2w_rd_addr line %0d", wb_idx), m2w_rd_addr, rd_q[wb_idx]);
            check_flag($sformatf("m2w_rd_wr line %0d", wb_idx), m2w_rd_wr,
                       op_q[wb_idx] != OP_ST);
            check_word($sformatf("m2w_rd_data line %0d", wb_idx), m2w_rd_data, exp_q[wb_idx]);
            check_flag($sformatf("m2w_fault line %0d", wb_idx), m2w_fault, fault_q[wb_idx]);
            check_addr($sformatf("m2w_ls_addr line %0d", wb_idx), m2w_ls_addr, addr_q[wb_idx]);
            check_flag($sformatf("timer strobe line %0d", wb_idx), strobe_cnt[wb_idx] != 0,
                       strobe_for(wb_idx) != 5'b0);
            wb_idx++;
         end
      end
   end

   // ----------------------------------------
   // golden file, reset, driver
   initial
   begin : main
      int          fd;
      string       line;
      logic [31:0] f_op, f_mode, f_addr, f_data, f_rd, f_exp, f_fault;
      cpu_halt     = 1'b0;
      pipe_flush   = 1'b0;
      arst_n       = 1'b0;
      e2m_valid    = 1'b0;
      e2m_is_ld    = 1'b0;
      e2m_is_st    = 1'b0;
      e2m_addr     = '0;
      e2m_st_data  = '0;
      e2m_size     = 3'd4;
      e2m_zero_ext = 1'b0;
      e2m_mode     = '0;
      e2m_rd_wr    = 1'b0;
      e2m_rd_addr  = '0;
      e2m_rd_data  = '0;
      mtime        = MTIME_VAL;
      mtimecmp     = CMP_VAL;
      msip_reg     = 32'h0000_0001;

      fd = $fopen("testbench/mem_stage_golden.txt", "r");
      if (fd == 0)
         abort_run("cannot open testbench/mem_stage_golden.txt");
      while (!$feof(fd) && n_lines < MAX_LINES)
      begin
         line = "";
         if ($fgets(line, fd) == 0)
            break;
         if (line.len() < 2 || line[0] == "#")
            continue;                          // blank or column header
         if ($sscanf(line, "%h %h %h %h %h %h %h",
                     f_op, f_mode, f_addr, f_data, f_rd, f_exp, f_fault) == 7)
         begin
            op_q[n_lines]       = f_op[3:0];
            mode_q[n_lines]     = f_mode[1:0];
            addr_q[n_lines]     = f_addr;
            data_q[n_lines]     = f_data;
            rd_q[n_lines]       = f_rd[4:0];
            exp_q[n_lines]      = f_exp;
            fault_q[n_lines]    = f_fault[0];
            strobe_cnt[n_lines] = 0;
            n_lines++;
         end
      end
      $fclose(fd);
      cycle_limit = n_lines * 12 + 16;        // reset and drain margin

      repeat (4) @(posedge clk_in);
      arst_n <= 1'b1;

      for (int i = 0; i < n_lines; i++)
      begin
         @(posedge clk_in);
         cur = i;
         e2m_valid    <= 1'b1;
         e2m_is_ld    <= (op_q[i] == OP_LD);
         e2m_is_st    <= (op_q[i] == OP_ST);
         e2m_addr     <= addr_q[i];
         e2m_st_data  <= data_q[i];
         e2m_zero_ext <= rd_q[i][0];          // toggles the pass-through flag
         e2m_mode     <= mode_q[i];
         e2m_rd_wr    <= (op_q[i] != OP_ST);
         e2m_rd_addr  <= rd_q[i];
         e2m_rd_data  <= data_q[i];
         @(negedge clk_in);
         while (!e2m_rdy)
            @(negedge clk_in);                 // transfer on the next rising edge
      end
      @(posedge clk_in);
      e2m_valid <= 1'b0;

      while (wb_idx < n_lines)
         @(negedge clk_in);
      @(posedge clk_in);
      if (n_lines > 0 && wb_idx == n_lines)
      begin
         $display("TEST PASS");
         $finish;
      end
      else
         abort_run("golden file held no access lines");
   end

endmodule
